// File: source/image_pkg.sv
// Image capture package with data widths, host opcodes and packer states.
package image_pkg;

    parameter int PIXEL_WIDTH = 8;  // One pixel is one byte.
    parameter int WORD_WIDTH  = 32; // A buffer word holds four pixel bytes.

    // Host command opcodes.
    typedef enum logic [1:0] {
        OP_NOP       = 2'd0, // No operation.
        OP_START     = 2'd1, // Arm a capture and clear the done flag.
        OP_SET_ADDR  = 2'd2, // Load the read pointer from the command data.
        OP_READ_NEXT = 2'd3  // Step the read pointer by one byte.
    } host_op_t;

    // Pixel packer states.
    typedef enum logic [1:0] {
        ST_IDLE       = 2'd0, // Not armed.
        ST_WAIT_FRAME = 2'd1, // Armed, waiting for the frame to start.
        ST_CAPTURE    = 2'd2, // Storing pixel bytes.
        ST_FLUSH      = 2'd3  // Writing the last partial word.
    } packer_state_t;

endpackage

// File: source/capture_regs.sv
// Host command decoder that arms captures, keeps the done flag and moves the read pointer.
module capture_regs #(
    parameter int BUFFER_WORDS = 16384
) (
    input  logic                                  clock_i,
    input  logic                                  rst_n_i,

    input  logic                                  cmd_valid_i,
    input  image_pkg::host_op_t                   cmd_opcode_i,
    input  logic [15:0]                           cmd_data_i,

    input  logic                                  packer_done_i,
    output logic                                  arm_o,
    output logic                                  capture_done_o,

    output logic [$clog2(BUFFER_WORDS*4)-1:0]     read_address_o
);

    localparam int BUFFER_BYTES = BUFFER_WORDS * 4;
    localparam int ADDR_WIDTH   = $clog2(BUFFER_BYTES); // At most 16 bits for the default depth.

    logic                  start_cmd;
    logic                  arm_q;
    logic                  done_q;
    logic [ADDR_WIDTH-1:0] read_ptr_q;
    logic [ADDR_WIDTH-1:0] read_ptr_next;

    assign start_cmd = cmd_valid_i && (cmd_opcode_i == image_pkg::OP_START);

    // The pointer wraps back to zero at the end of the buffer.
    assign read_ptr_next = (read_ptr_q == ADDR_WIDTH'(BUFFER_BYTES - 1)) ? '0
                                                                          : read_ptr_q + 1'b1;

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            arm_q      <= 1'b0;
            done_q     <= 1'b0;
            read_ptr_q <= '0;
        end else begin
            arm_q <= start_cmd; // Arm pulse follows the accepted start by one cycle.

            // A new start wins over a done from the capture it replaces.
            if (start_cmd) begin
                done_q <= 1'b0;
            end else if (packer_done_i) begin
                done_q <= 1'b1; // Sticky until the next start.
            end

            if (cmd_valid_i) begin
                unique case (cmd_opcode_i)
                    image_pkg::OP_SET_ADDR: begin
                        read_ptr_q <= cmd_data_i[ADDR_WIDTH-1:0];
                    end
                    image_pkg::OP_READ_NEXT: begin
                        read_ptr_q <= read_ptr_next;
                    end
                    image_pkg::OP_START,
                    image_pkg::OP_NOP: begin
                        read_ptr_q <= read_ptr_q; // Pointer holds.
                    end
                    default: begin
                        read_ptr_q <= read_ptr_q;
                    end
                endcase
            end
        end
    end

    assign arm_o          = arm_q;
    assign capture_done_o = done_q;
    assign read_address_o = read_ptr_q;

endmodule

// File: source/pixel_packer.sv
// Frame capture FSM that packs pixel bytes into buffer words and counts stored bytes.
module pixel_packer #(
    parameter int BUFFER_WORDS = 16384
) (
    input  logic                                  clock_i,
    input  logic                                  rst_n_i,

    input  logic                                  arm_i,
    input  logic                                  frame_valid_i,
    input  logic                                  pixel_valid_i,
    input  logic [image_pkg::PIXEL_WIDTH-1:0]     pixel_data_i,

    output logic                                  write_enable_o,
    output logic [$clog2(BUFFER_WORDS)-1:0]       write_address_o,
    output logic [image_pkg::WORD_WIDTH-1:0]      write_data_o,

    output logic                                  done_o,
    output logic                                  busy_o,
    output logic [$clog2(BUFFER_WORDS*4):0]       byte_count_o
);

    localparam int BUFFER_BYTES = BUFFER_WORDS * 4;
    localparam int WADDR_WIDTH  = $clog2(BUFFER_WORDS);
    localparam int COUNT_WIDTH  = $clog2(BUFFER_BYTES) + 1;
    localparam int PART_WIDTH   = image_pkg::WORD_WIDTH - image_pkg::PIXEL_WIDTH;

    image_pkg::packer_state_t state_q, state_d;

    logic                                frame_q;
    logic [1:0]                          lane_q;
    logic [PART_WIDTH-1:0]               word_q;
    logic [WADDR_WIDTH-1:0]              word_address_q;
    logic [COUNT_WIDTH-1:0]              byte_count_q;
    logic                                write_enable_q;
    logic [WADDR_WIDTH-1:0]              write_address_q;
    logic [image_pkg::WORD_WIDTH-1:0]    write_data_q;
    logic                                frame_rise;
    logic                                frame_fall;
    logic                                full;
    logic                                store;
    logic                                word_done;
    logic                                flush_write;

    assign frame_rise = frame_valid_i && !frame_q;
    assign frame_fall = !frame_valid_i && frame_q;
    assign full       = (byte_count_q == COUNT_WIDTH'(BUFFER_BYTES)); // Extra bytes are dropped.

    // A pixel in the first cycle of the frame is kept as well.
    assign store = pixel_valid_i && frame_valid_i && !full && !arm_i &&
                   ((state_q == image_pkg::ST_CAPTURE) ||
                    ((state_q == image_pkg::ST_WAIT_FRAME) && frame_rise));
    assign word_done   = store && (lane_q == 2'd3);
    assign flush_write = (state_q == image_pkg::ST_FLUSH) && (lane_q != 2'd0);

    always_comb begin
        state_d = state_q;
        if (arm_i) begin
            state_d = image_pkg::ST_WAIT_FRAME; // Re-arming restarts the capture.
        end else begin
            case (state_q)
                image_pkg::ST_IDLE:       state_d = image_pkg::ST_IDLE;
                image_pkg::ST_WAIT_FRAME: if (frame_rise) state_d = image_pkg::ST_CAPTURE;
                image_pkg::ST_CAPTURE:    if (frame_fall) state_d = image_pkg::ST_FLUSH;
                image_pkg::ST_FLUSH:      state_d = image_pkg::ST_IDLE;
                default:                  state_d = image_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q        <= image_pkg::ST_IDLE;
            frame_q        <= 1'b0;
            lane_q         <= 2'd0;
            word_address_q <= '0;
            byte_count_q   <= '0;
            write_enable_q <= 1'b0;
        end else begin
            state_q        <= state_d;
            frame_q        <= frame_valid_i;
            write_enable_q <= word_done || flush_write; // Buffer writes on the next falling edge.
            if (arm_i) begin
                lane_q         <= 2'd0;
                word_address_q <= '0;
                byte_count_q   <= '0;
            end else if (store) begin
                lane_q       <= lane_q + 2'd1;
                byte_count_q <= byte_count_q + 1'b1;
                if (lane_q == 2'd3) begin
                    word_address_q <= word_address_q + 1'b1;
                end
            end
        end
    end

    // Lane 0 clears the upper lanes so a flushed partial word is zero padded.
    always_ff @(posedge clock_i) begin
        if (store) begin
            case (lane_q)
                2'd0: word_q <= PART_WIDTH'(pixel_data_i);
                2'd1: word_q[image_pkg::PIXEL_WIDTH +: image_pkg::PIXEL_WIDTH] <= pixel_data_i;
                2'd2: word_q[2*image_pkg::PIXEL_WIDTH +: image_pkg::PIXEL_WIDTH] <= pixel_data_i;
                default: word_q <= word_q;
            endcase
        end
        if (word_done) begin
            write_data_q    <= {pixel_data_i, word_q};
            write_address_q <= word_address_q;
        end else if (flush_write) begin
            write_data_q    <= {{image_pkg::PIXEL_WIDTH{1'b0}}, word_q};
            write_address_q <= word_address_q;
        end
    end

    assign write_enable_o  = write_enable_q;
    assign write_address_o = write_address_q;
    assign write_data_o    = write_data_q;
    assign done_o          = (state_q == image_pkg::ST_FLUSH) && !arm_i;
    assign busy_o          = (state_q != image_pkg::ST_IDLE);
    assign byte_count_o    = byte_count_q;

endmodule

// File: source/image_buffer.sv
// Dual-port image RAM on the falling edge with word writes and byte reads.
module image_buffer #(
    parameter int BUFFER_WORDS = 16384
) (
    input  logic                                  clock_i,
    input  logic                                  rst_n_i,

    input  logic [$clog2(BUFFER_WORDS)-1:0]       write_address_i,
    input  logic [$clog2(BUFFER_WORDS*4)-1:0]     read_address_i,

    input  logic [image_pkg::WORD_WIDTH-1:0]      write_data_i,
    input  logic                                  write_enable_i,
    output logic [image_pkg::PIXEL_WIDTH-1:0]     read_data_o
);

    localparam int WADDR_WIDTH = $clog2(BUFFER_WORDS);
    localparam int RADDR_WIDTH = $clog2(BUFFER_WORDS * 4);
    localparam int PW          = image_pkg::PIXEL_WIDTH;

    logic [image_pkg::WORD_WIDTH-1:0] mem [BUFFER_WORDS];
    logic [image_pkg::WORD_WIDTH-1:0] q;
    logic [WADDR_WIDTH-1:0]           read_word_q;
    logic [1:0]                       lane_d1_q;
    logic [1:0]                       lane_d2_q;

    // Word address and lane select are captured together on the first edge.
    always_ff @(negedge clock_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            read_word_q <= '0;
            lane_d1_q   <= 2'd0;
            lane_d2_q   <= 2'd0;
        end else begin
            read_word_q <= read_address_i[RADDR_WIDTH-1:2];
            lane_d1_q   <= read_address_i[1:0];
            lane_d2_q   <= lane_d1_q; // Lines up with the registered data word.
        end
    end

    always_ff @(negedge clock_i) begin
        if (write_enable_i) begin
            mem[write_address_i] <= write_data_i;
        end
        q <= mem[read_word_q];
    end

    always_comb begin
        case (lane_d2_q)
            2'd0:    read_data_o = q[0*PW +: PW];
            2'd1:    read_data_o = q[1*PW +: PW];
            2'd2:    read_data_o = q[2*PW +: PW];
            default: read_data_o = q[3*PW +: PW];
        endcase
    end

endmodule

// File: source/image_capture_top.sv
// Camera frame capture top level joining the host command block, pixel packer and image RAM.
module image_capture_top #(
    parameter int BUFFER_WORDS = 16384
) (
    input  logic                                  clock_i,
    input  logic                                  rst_n_i,

    input  logic                                  cmd_valid_i,
    input  image_pkg::host_op_t                   cmd_opcode_i,
    input  logic [15:0]                           cmd_data_i,
    output logic                                  capture_done_o,
    output logic                                  busy_o,
    output logic [$clog2(BUFFER_WORDS*4):0]       image_bytes_o,
    output logic [image_pkg::PIXEL_WIDTH-1:0]     read_data_o,

    input  logic                                  frame_valid_i,
    input  logic                                  pixel_valid_i,
    input  logic [image_pkg::PIXEL_WIDTH-1:0]     pixel_data_i
);

    logic                                  arm;
    logic                                  packer_done;
    logic                                  write_enable;
    logic [$clog2(BUFFER_WORDS)-1:0]       write_address;
    logic [image_pkg::WORD_WIDTH-1:0]      write_data;
    logic [$clog2(BUFFER_WORDS*4)-1:0]     read_address;

    capture_regs #(
        .BUFFER_WORDS   (BUFFER_WORDS)
    ) u_capture_regs (
        .clock_i        (clock_i),
        .rst_n_i        (rst_n_i),
        .cmd_valid_i    (cmd_valid_i),
        .cmd_opcode_i   (cmd_opcode_i),
        .cmd_data_i     (cmd_data_i),
        .packer_done_i  (packer_done),
        .arm_o          (arm),
        .capture_done_o (capture_done_o),
        .read_address_o (read_address)
    );

    pixel_packer #(
        .BUFFER_WORDS    (BUFFER_WORDS)
    ) u_pixel_packer (
        .clock_i         (clock_i),
        .rst_n_i         (rst_n_i),
        .arm_i           (arm),
        .frame_valid_i   (frame_valid_i),
        .pixel_valid_i   (pixel_valid_i),
        .pixel_data_i    (pixel_data_i),
        .write_enable_o  (write_enable),
        .write_address_o (write_address),
        .write_data_o    (write_data),
        .done_o          (packer_done),
        .busy_o          (busy_o),
        .byte_count_o    (image_bytes_o)
    );

    image_buffer #(
        .BUFFER_WORDS    (BUFFER_WORDS)
    ) u_image_buffer (
        .clock_i         (clock_i),
        .rst_n_i         (rst_n_i),
        .write_address_i (write_address),
        .read_address_i  (read_address),
        .write_data_i    (write_data),
        .write_enable_i  (write_enable),
        .read_data_o     (read_data_o)
    );

endmodule

// File: verif/image_capture_tb.sv
// Testbench for the camera frame capture subsystem with a byte-level reference memory.
module image_capture_tb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int BUFFER_WORDS   = 64;
    localparam int BUFFER_BYTES   = BUFFER_WORDS * 4;
    localparam int DRIVE_DELAY    = 1;
    // Four frames of up to 300 pixels with gaps, plus readback at three cycles per byte.
    localparam int TIMEOUT_CYCLES = 4000;

    logic                                  clock_i;
    logic                                  rst_n_i;
    logic                                  cmd_valid_i;
    image_pkg::host_op_t                   cmd_opcode_i;
    logic [15:0]                           cmd_data_i;
    logic                                  capture_done_o;
    logic                                  busy_o;
    logic [$clog2(BUFFER_BYTES):0]         image_bytes_o;
    logic [image_pkg::PIXEL_WIDTH-1:0]     read_data_o;
    logic                                  frame_valid_i;
    logic                                  pixel_valid_i;
    logic [image_pkg::PIXEL_WIDTH-1:0]     pixel_data_i;

    logic [7:0] model_mem [BUFFER_BYTES]; // Expected buffer contents, one entry per byte.
    int         seed;
    int         cycle_count = 0;

    image_capture_top #(
        .BUFFER_WORDS   (BUFFER_WORDS)
    ) u_dut (
        .clock_i        (clock_i),
        .rst_n_i        (rst_n_i),
        .cmd_valid_i    (cmd_valid_i),
        .cmd_opcode_i   (cmd_opcode_i),
        .cmd_data_i     (cmd_data_i),
        .capture_done_o (capture_done_o),
        .busy_o         (busy_o),
        .image_bytes_o  (image_bytes_o),
        .read_data_o    (read_data_o),
        .frame_valid_i  (frame_valid_i),
        .pixel_valid_i  (pixel_valid_i),
        .pixel_data_i   (pixel_data_i)
    );

    initial begin
        clock_i = 1'b0;
        forever #5 clock_i = ~clock_i; // 10 ns period.
    end

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Run stopped on the first failure.");
    endtask

    task automatic report_error(input string name, input logic [31:0] expected,
                                input logic [31:0] actual);
        stop_run($sformatf("ERROR at %0t: %s expected 0x%0h, actual 0x%0h",
                           $time, name, expected, actual));
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected) else report_error(name, expected, actual);
    endtask

    // A done capture leaves the packer idle, and the count never exceeds the buffer.
    assert property (@(posedge clock_i) disable iff (!rst_n_i) !(capture_done_o && busy_o))
        else report_error("capture_done_o & busy_o", 32'd0, 32'd1);
    assert property (@(posedge clock_i) disable iff (!rst_n_i) image_bytes_o <= BUFFER_BYTES)
        else report_error("image_bytes_o", BUFFER_BYTES, image_bytes_o);

    always @(posedge clock_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_run($sformatf("Timeout: the run did not end within %0d clock cycles.",
                               TIMEOUT_CYCLES));
        end
    end

    // Outputs are sampled and inputs driven just after each rising edge.
    task automatic tick();
        @(posedge clock_i);
        #DRIVE_DELAY;
    endtask

    task automatic send_command(input image_pkg::host_op_t op, input int data);
        cmd_valid_i  = 1'b1;
        cmd_opcode_i = op;
        cmd_data_i   = 16'(data);
        tick();
        cmd_valid_i  = 1'b0;
        cmd_opcode_i = image_pkg::OP_NOP;
    endtask

    task automatic start_capture();
        send_command(image_pkg::OP_START, 0);
        check_value("capture_done_o", 32'd0, capture_done_o); // Cleared by the accepted start.
        tick();
        check_value("busy_o", 32'd1, busy_o); // Packer now waits for the frame.
    endtask

    task automatic send_frame(input int n_pixels, input bit armed);
        int         sent;
        logic [7:0] pixel;
        sent = 0;
        frame_valid_i = 1'b1;
        while (sent < n_pixels) begin
            if (($random(seed) & 3) != 0) begin
                pixel         = 8'($random(seed));
                pixel_valid_i = 1'b1;
                pixel_data_i  = pixel;
                if (armed && sent < BUFFER_BYTES) begin
                    model_mem[sent] = pixel;
                end
                sent++;
            end else begin
                pixel_valid_i = 1'b0; // Random gap between pixels.
            end
            tick();
        end
        frame_valid_i = 1'b0;
        pixel_valid_i = 1'b0;
        if (armed && n_pixels < BUFFER_BYTES) begin
            for (int i = n_pixels; i % 4 != 0; i++) begin
                model_mem[i] = 8'h00; // Upper lanes of the flushed word.
            end
        end
    endtask

    task automatic wait_done(input int expected_bytes);
        int waited;
        waited = 0;
        while (!capture_done_o && waited < 3) begin
            tick();
            waited++;
        end
        check_value("capture_done_o", 32'd1, capture_done_o);
        check_value("image_bytes_o", expected_bytes, image_bytes_o);
    endtask

    // Read data is valid at the second rising edge after the pointer moves.
    task automatic read_sequence(input int first, input int count);
        for (int i = 0; i < count; i++) begin
            if (i == 0) begin
                send_command(image_pkg::OP_SET_ADDR, first);
            end else begin
                send_command(image_pkg::OP_READ_NEXT, 0);
            end
            tick();
            tick();
            check_value($sformatf("read_data_o[%0d]", first + i),
                        model_mem[first + i], read_data_o);
        end
    endtask

    task automatic read_random(input int count);
        int address;
        for (int i = 0; i < count; i++) begin
            address = $random(seed) & (BUFFER_BYTES - 1);
            send_command(image_pkg::OP_SET_ADDR, address);
            tick();
            tick();
            check_value($sformatf("read_data_o[%0d]", address), model_mem[address], read_data_o);
        end
    endtask

    initial begin
        seed          = 32'h3c61;
        rst_n_i       = 1'b0;
        cmd_valid_i   = 1'b0;
        cmd_opcode_i  = image_pkg::OP_NOP;
        cmd_data_i    = 16'h0000;
        frame_valid_i = 1'b0;
        pixel_valid_i = 1'b0;
        pixel_data_i  = 8'h00;
        repeat (16) @(posedge clock_i);
        #DRIVE_DELAY;
        rst_n_i = 1'b1;
        tick();

        check_value("capture_done_o", 32'd0, capture_done_o);
        check_value("busy_o", 32'd0, busy_o);
        check_value("image_bytes_o", 32'd0, image_bytes_o);

        start_capture(); // Basic capture of a short frame.
        send_frame(37, 1'b1);
        wait_done(37);
        read_sequence(0, 40);

        send_frame(40, 1'b0); // Nobody armed this frame.
        repeat (4) tick();
        check_value("capture_done_o", 32'd1, capture_done_o);
        check_value("image_bytes_o", 32'd37, image_bytes_o);
        read_sequence(0, 40);

        start_capture(); // Frame longer than the buffer.
        send_frame(300, 1'b1);
        wait_done(BUFFER_BYTES);
        read_random(64);

        start_capture(); // New capture over the old image.
        send_frame(50, 1'b1);
        wait_done(50);
        read_sequence(0, 52);
        read_random(32);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: compile.f
source/image_pkg.sv
source/capture_regs.sv
source/pixel_packer.sv
source/image_buffer.sv
source/image_capture_top.sv
verif/image_capture_tb.sv

// File: Makefile
# Verilator build and run for the image capture testbench.

VERILATOR  ?= verilator
TOP        := image_capture_tb
RTL_TOP    := image_capture_top
FILELIST   := compile.f
BUILD_DIR  := obj_dir
SIM_FLAGS  := --binary --timing --assert -sv --Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -sv -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST)

# The simulator exits with a failing status when the testbench stops on $fatal.
run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)
